//--- Bender.yml
package:
  name: mc_core

sources:
  # Packages first, then the design
  - mc_core_pkg.sv
  - mc_bus_pkg.sv
  - mc_fetch.sv
  - mc_lsu.sv
  - mc_controller.sv
  - mc_core_top.sv

  # Testbench, assertions and top
  - target: simulation
    files:
      - mc_core_props.sv
      - tb_bus_responder.sv
      - tb_mc_checker.sv
      - tb_mc_top.sv

//--- mc_bus_pkg.sv
// ####################
// Request/grant/rvalid bus types, same on instruction and data side
// ####################

`default_nettype none

package mc_bus_pkg;

  localparam int BUS_AW = 12;
  localparam int BUS_DW = 16;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [BUS_DW-1:0] rdata;
    logic              err;
  } bus_rsp_t;

  // Master sequencing, one transaction in flight
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_REQ,
    BUS_WAIT
  } bus_state_e;

endpackage

`default_nettype wire

//--- mc_controller.sv
// ####################
// Decode/execute FSM of the mc core
// Holds pc and accumulator, drives retirement, sleep and alerts
// ####################

`timescale 1ns/1ns
`default_nettype none

module mc_controller (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             fetch_enable_i,
  output logic                             fetch_start_o,
  output logic [mc_core_pkg::ALEN-1:0]     fetch_addr_o,
  input  logic                             fetch_done_i,
  input  logic [mc_core_pkg::XLEN-1:0]     fetch_instr_i,
  input  logic                             fetch_err_i,
  output logic                             mem_start_o,
  output logic                             mem_we_o,
  output logic [mc_core_pkg::ALEN-1:0]     mem_addr_o,
  output logic [mc_core_pkg::XLEN-1:0]     mem_wdata_o,
  input  logic                             mem_done_i,
  input  logic [mc_core_pkg::XLEN-1:0]     mem_rdata_i,
  input  logic                             mem_err_i,
  output logic                             retire_valid_o,
  output mc_core_pkg::retire_t             retire_o,
  output logic                             core_sleep_o,
  output logic                             alert_major_bus_o,
  output logic                             alert_illegal_o
);

  mc_core_pkg::ctrl_state_e        state_q;
  mc_core_pkg::ctrl_state_e        state_d;
  logic [mc_core_pkg::ALEN-1:0]    pc_q;
  logic [mc_core_pkg::ALEN-1:0]    pc_d;
  logic [mc_core_pkg::XLEN-1:0]    acc_q;
  logic [mc_core_pkg::XLEN-1:0]    acc_d;
  logic [mc_core_pkg::XLEN-1:0]    imm_ext;
  mc_core_pkg::instr_t             ir_q;
  mc_core_pkg::instr_t             cur_instr;
  mc_core_pkg::retire_t            retire_q;
  logic                            is_mem;
  logic                            is_halt;
  logic                            is_illegal;
  logic                            fetch_ok;
  logic                            fetch_bad;
  logic                            mem_ok;
  logic                            mem_bad;
  logic                            retire_d;
  logic                            retire_valid_q;
  logic                            sleep_q;
  logic                            alert_bus_q;
  logic                            alert_ill_q;

  // Decode straight from the bus on fetch_done, else from the held instruction
  assign cur_instr = (state_q == mc_core_pkg::ST_FETCH) ?
                     mc_core_pkg::instr_t'(fetch_instr_i) : ir_q;
  assign imm_ext   = mc_core_pkg::XLEN'(cur_instr.operand);

  always_comb begin
    acc_d      = acc_q;
    pc_d       = pc_q + mc_core_pkg::ALEN'(1);
    is_mem     = 1'b0;
    is_halt    = 1'b0;
    is_illegal = 1'b0;
    case (cur_instr.opcode)
      mc_core_pkg::OP_LDI:  acc_d = imm_ext;
      mc_core_pkg::OP_LD: begin
        is_mem = 1'b1;
        acc_d  = mem_rdata_i;
      end
      mc_core_pkg::OP_ST:   is_mem = 1'b1;
      // Wraps modulo 2^16
      mc_core_pkg::OP_ADD: begin
        is_mem = 1'b1;
        acc_d  = acc_q + mem_rdata_i;
      end
      mc_core_pkg::OP_XORI: acc_d = acc_q ^ imm_ext;
      mc_core_pkg::OP_BEQZ: begin
        if (acc_q == '0) begin
          pc_d = cur_instr.operand;
        end
      end
      mc_core_pkg::OP_JMP:  pc_d = cur_instr.operand;
      mc_core_pkg::OP_HALT: is_halt = 1'b1;
      default:              is_illegal = 1'b1;
    endcase
  end

  // Bus error wins over an illegal code read with it
  assign fetch_ok  = (state_q == mc_core_pkg::ST_FETCH) && fetch_done_i && !fetch_err_i;
  assign fetch_bad = (state_q == mc_core_pkg::ST_FETCH) && fetch_done_i && fetch_err_i;
  assign mem_ok    = (state_q == mc_core_pkg::ST_MEM) && mem_done_i && !mem_err_i;
  assign mem_bad   = (state_q == mc_core_pkg::ST_MEM) && mem_done_i && mem_err_i;
  assign retire_d  = (fetch_ok && !is_illegal && !is_mem) || mem_ok;

  always_comb begin
    state_d       = state_q;
    fetch_start_o = 1'b0;
    mem_start_o   = 1'b0;
    case (state_q)
      // Enable is only sampled ahead of a new fetch
      mc_core_pkg::ST_IDLE: begin
        if (fetch_enable_i) begin
          fetch_start_o = 1'b1;
          state_d       = mc_core_pkg::ST_FETCH;
        end
      end
      mc_core_pkg::ST_FETCH: begin
        if (fetch_bad || (fetch_ok && is_illegal)) begin
          state_d = mc_core_pkg::ST_FAULT;
        end else if (fetch_ok && is_mem) begin
          state_d = mc_core_pkg::ST_EXEC;
        end else if (fetch_ok && is_halt) begin
          state_d = mc_core_pkg::ST_SLEEP;
        end else if (fetch_ok) begin
          state_d = mc_core_pkg::ST_IDLE;
        end
      end
      // One cycle to launch the data access
      mc_core_pkg::ST_EXEC: begin
        mem_start_o = 1'b1;
        state_d     = mc_core_pkg::ST_MEM;
      end
      mc_core_pkg::ST_MEM: begin
        if (mem_bad) begin
          state_d = mc_core_pkg::ST_FAULT;
        end else if (mem_ok) begin
          state_d = mc_core_pkg::ST_IDLE;
        end
      end
      mc_core_pkg::ST_SLEEP: state_d = mc_core_pkg::ST_SLEEP;
      default:               state_d = mc_core_pkg::ST_FAULT;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q        <= mc_core_pkg::ST_IDLE;
      pc_q           <= '0;
      acc_q          <= '0;
      retire_valid_q <= 1'b0;
      sleep_q        <= 1'b0;
      alert_bus_q    <= 1'b0;
      alert_ill_q    <= 1'b0;
    end else begin
      state_q        <= state_d;
      retire_valid_q <= retire_d;
      if (retire_d) begin
        pc_q  <= pc_d;
        acc_q <= acc_d;
      end
      // Sticky levels, cleared by reset only
      if (retire_d && is_halt) begin
        sleep_q <= 1'b1;
      end
      if (fetch_bad || mem_bad) begin
        alert_bus_q <= 1'b1;
      end
      if (fetch_ok && is_illegal) begin
        alert_ill_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_ok) begin
      ir_q <= cur_instr;
    end
    if (retire_d) begin
      retire_q <= '{pc: pc_q, instr: cur_instr, acc: acc_d};
    end
  end

  assign fetch_addr_o      = pc_q;
  assign mem_we_o          = (ir_q.opcode == mc_core_pkg::OP_ST);
  assign mem_addr_o        = ir_q.operand;
  assign mem_wdata_o       = acc_q;
  assign retire_valid_o    = retire_valid_q;
  assign retire_o          = retire_q;
  assign core_sleep_o      = sleep_q;
  assign alert_major_bus_o = alert_bus_q;
  assign alert_illegal_o   = alert_ill_q;

endmodule

`default_nettype wire

//--- mc_core_pkg.sv
// ####################
// Core-side types for the mc accumulator core
// Opcodes, controller states, instruction and retirement layouts
// ####################

`default_nettype none

package mc_core_pkg;

  // Accumulator/data width and word address width
  localparam int XLEN = 16;
  localparam int ALEN = 12;

  // Codes 8 to 15 decode as illegal
  typedef enum logic [3:0] {
    OP_LDI  = 4'h0,
    OP_LD   = 4'h1,
    OP_ST   = 4'h2,
    OP_ADD  = 4'h3,
    OP_XORI = 4'h4,
    OP_BEQZ = 4'h5,
    OP_JMP  = 4'h6,
    OP_HALT = 4'h7
  } opcode_e;

  typedef struct packed {
    opcode_e         opcode;
    logic [ALEN-1:0] operand;
  } instr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_SLEEP,
    ST_FAULT
  } ctrl_state_e;

  // Accumulator value is the one after the instruction
  typedef struct packed {
    logic [ALEN-1:0] pc;
    instr_t          instr;
    logic [XLEN-1:0] acc;
  } retire_t;

endpackage

`default_nettype wire

//--- mc_core_props.sv
// ####################
// Bus and status assertions for the mc core
// Bound into mc_core_top
// ####################

`timescale 1ns/1ns
`default_nettype none

module mc_core_props (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  mc_bus_pkg::bus_req_t instr_req_i,
  input  mc_bus_pkg::bus_rsp_t instr_rsp_i,
  input  mc_bus_pkg::bus_req_t data_req_i,
  input  mc_bus_pkg::bus_rsp_t data_rsp_i,
  input  logic                 retire_valid_i,
  input  logic                 stopped_i
);

  int   violations = 0;
  logic instr_open_q;
  logic data_open_q;

  // One outstanding transaction per bus
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_open_q <= 1'b0;
      data_open_q  <= 1'b0;
    end else begin
      if (instr_req_i.req && instr_rsp_i.gnt) begin
        instr_open_q <= 1'b1;
      end else if (instr_rsp_i.rvalid) begin
        instr_open_q <= 1'b0;
      end
      if (data_req_i.req && data_rsp_i.gnt) begin
        data_open_q <= 1'b1;
      end else if (data_rsp_i.rvalid) begin
        data_open_q <= 1'b0;
      end
    end
  end

  instr_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_req_i.req && !instr_rsp_i.gnt |=> $stable(instr_req_i))
    else begin
      $error("instruction request changed before its grant");
      violations++;
    end

  data_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_req_i.req && !data_rsp_i.gnt |=> $stable(data_req_i))
    else begin
      $error("data request changed before its grant");
      violations++;
    end

  instr_rvalid_open: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_rsp_i.rvalid |-> instr_open_q)
    else begin
      $error("instruction rvalid without an outstanding request");
      violations++;
    end

  data_rvalid_open: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_rsp_i.rvalid |-> data_open_q)
    else begin
      $error("data rvalid without an outstanding request");
      violations++;
    end

  // Nothing retires once the core sleeps or alerts
  no_retire_stopped: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stopped_i |=> !retire_valid_i)
    else begin
      $error("retirement while the core is asleep or alerted");
      violations++;
    end

  instr_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !instr_req_i.we && (instr_req_i.wdata == '0))
    else begin
      $error("write enable or write data seen on the instruction bus");
      violations++;
    end

endmodule

bind mc_core_top mc_core_props u_props (
  .clk_i          (clk_i                                                  ),
  .arst_n_i       (arst_n_i                                               ),
  .instr_req_i    (instr_req_o                                            ),
  .instr_rsp_i    (instr_rsp_i                                            ),
  .data_req_i     (data_req_o                                             ),
  .data_rsp_i     (data_rsp_i                                             ),
  .retire_valid_i (retire_valid_o                                         ),
  .stopped_i      (core_sleep_o | alert_major_bus_o | alert_illegal_o     )
);

`default_nettype wire

//--- mc_core_top.sv
// ####################
// mc core top, fetch unit, load/store unit and controller
// Instruction and data buses leave here unchanged
// ####################

`timescale 1ns/1ns
`default_nettype none

module mc_core_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 fetch_enable_i,
  output mc_bus_pkg::bus_req_t instr_req_o,
  input  mc_bus_pkg::bus_rsp_t instr_rsp_i,
  output mc_bus_pkg::bus_req_t data_req_o,
  input  mc_bus_pkg::bus_rsp_t data_rsp_i,
  output logic                 retire_valid_o,
  output mc_core_pkg::retire_t retire_o,
  output logic                 core_sleep_o,
  output logic                 alert_major_bus_o,
  output logic                 alert_illegal_o
);

  // Controller to fetch unit
  logic                         fetch_start;
  logic [mc_core_pkg::ALEN-1:0] fetch_addr;
  logic                         fetch_done;
  logic [mc_core_pkg::XLEN-1:0] fetch_instr;
  logic                         fetch_err;

  // Controller to load/store unit
  logic                         mem_start;
  logic                         mem_we;
  logic [mc_core_pkg::ALEN-1:0] mem_addr;
  logic [mc_core_pkg::XLEN-1:0] mem_wdata;
  logic                         mem_done;
  logic [mc_core_pkg::XLEN-1:0] mem_rdata;
  logic                         mem_err;

  mc_fetch u_fetch (
    .clk_i         (clk_i      ),
    .arst_n_i      (arst_n_i   ),
    .fetch_start_i (fetch_start),
    .fetch_addr_i  (fetch_addr ),
    .instr_req_o   (instr_req_o),
    .instr_rsp_i   (instr_rsp_i),
    .fetch_done_o  (fetch_done ),
    .fetch_instr_o (fetch_instr),
    .fetch_err_o   (fetch_err  )
  );

  mc_lsu u_lsu (
    .clk_i       (clk_i     ),
    .arst_n_i    (arst_n_i  ),
    .mem_start_i (mem_start ),
    .mem_we_i    (mem_we    ),
    .mem_addr_i  (mem_addr  ),
    .mem_wdata_i (mem_wdata ),
    .data_req_o  (data_req_o),
    .data_rsp_i  (data_rsp_i),
    .mem_done_o  (mem_done  ),
    .mem_rdata_o (mem_rdata ),
    .mem_err_o   (mem_err   )
  );

  mc_controller u_ctrl (
    .clk_i             (clk_i            ),
    .arst_n_i          (arst_n_i         ),
    .fetch_enable_i    (fetch_enable_i   ),
    .fetch_start_o     (fetch_start      ),
    .fetch_addr_o      (fetch_addr       ),
    .fetch_done_i      (fetch_done       ),
    .fetch_instr_i     (fetch_instr      ),
    .fetch_err_i       (fetch_err        ),
    .mem_start_o       (mem_start        ),
    .mem_we_o          (mem_we           ),
    .mem_addr_o        (mem_addr         ),
    .mem_wdata_o       (mem_wdata        ),
    .mem_done_i        (mem_done         ),
    .mem_rdata_i       (mem_rdata        ),
    .mem_err_i         (mem_err          ),
    .retire_valid_o    (retire_valid_o   ),
    .retire_o          (retire_o         ),
    .core_sleep_o      (core_sleep_o     ),
    .alert_major_bus_o (alert_major_bus_o),
    .alert_illegal_o   (alert_illegal_o  )
  );

endmodule

`default_nettype wire

//--- mc_fetch.sv
// ####################
// Instruction bus master, one fetch per start pulse from the controller
// ####################

`timescale 1ns/1ns
`default_nettype none

module mc_fetch (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          fetch_start_i,
  input  logic [mc_bus_pkg::BUS_AW-1:0] fetch_addr_i,
  output mc_bus_pkg::bus_req_t          instr_req_o,
  input  mc_bus_pkg::bus_rsp_t          instr_rsp_i,
  output logic                          fetch_done_o,
  output logic [mc_bus_pkg::BUS_DW-1:0] fetch_instr_o,
  output logic                          fetch_err_o
);

  mc_bus_pkg::bus_state_e        state_q;
  mc_bus_pkg::bus_state_e        state_d;
  logic [mc_bus_pkg::BUS_AW-1:0] addr_q;
  logic [mc_bus_pkg::BUS_DW-1:0] rdata_q;
  logic                          err_q;
  logic                          done_q;
  logic                          rsp_seen;

  assign rsp_seen = (state_q == mc_bus_pkg::BUS_WAIT) && instr_rsp_i.rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mc_bus_pkg::BUS_IDLE: begin
        if (fetch_start_i) begin
          state_d = mc_bus_pkg::BUS_REQ;
        end
      end
      // Hold req until the grant cycle
      mc_bus_pkg::BUS_REQ: begin
        if (instr_rsp_i.gnt) begin
          state_d = mc_bus_pkg::BUS_WAIT;
        end
      end
      mc_bus_pkg::BUS_WAIT: begin
        if (instr_rsp_i.rvalid) begin
          state_d = mc_bus_pkg::BUS_IDLE;
        end
      end
      default: state_d = mc_bus_pkg::BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mc_bus_pkg::BUS_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= rsp_seen;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == mc_bus_pkg::BUS_IDLE) && fetch_start_i) begin
      addr_q <= fetch_addr_i;
    end
    if (rsp_seen) begin
      rdata_q <= instr_rsp_i.rdata;
      err_q   <= instr_rsp_i.err;
    end
  end

  // Read-only bus, we and wdata tied low
  always_comb begin
    instr_req_o      = '0;
    instr_req_o.req  = (state_q == mc_bus_pkg::BUS_REQ);
    instr_req_o.addr = addr_q;
  end

  assign fetch_done_o  = done_q;
  assign fetch_instr_o = rdata_q;
  assign fetch_err_o   = err_q;

endmodule

`default_nettype wire

//--- mc_lsu.sv
// ####################
// Data bus master for loads and stores issued by the controller
// ####################

`timescale 1ns/1ns
`default_nettype none

module mc_lsu (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          mem_start_i,
  input  logic                          mem_we_i,
  input  logic [mc_bus_pkg::BUS_AW-1:0] mem_addr_i,
  input  logic [mc_bus_pkg::BUS_DW-1:0] mem_wdata_i,
  output mc_bus_pkg::bus_req_t          data_req_o,
  input  mc_bus_pkg::bus_rsp_t          data_rsp_i,
  output logic                          mem_done_o,
  output logic [mc_bus_pkg::BUS_DW-1:0] mem_rdata_o,
  output logic                          mem_err_o
);

  mc_bus_pkg::bus_state_e state_q;
  mc_bus_pkg::bus_state_e state_d;
  mc_bus_pkg::bus_req_t   req_q;
  logic                   done_q;
  logic                   rsp_seen;
  logic [mc_bus_pkg::BUS_DW-1:0] rdata_q;
  logic                   err_q;

  assign rsp_seen = (state_q == mc_bus_pkg::BUS_WAIT) && data_rsp_i.rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mc_bus_pkg::BUS_IDLE: if (mem_start_i) state_d = mc_bus_pkg::BUS_REQ;
      mc_bus_pkg::BUS_REQ:  if (data_rsp_i.gnt) state_d = mc_bus_pkg::BUS_WAIT;
      // Stores wait for rvalid too, it carries err
      mc_bus_pkg::BUS_WAIT: if (data_rsp_i.rvalid) state_d = mc_bus_pkg::BUS_IDLE;
      default:              state_d = mc_bus_pkg::BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= mc_bus_pkg::BUS_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= rsp_seen;
    end
  end

  // Address, write enable and write data captured together
  always_ff @(posedge clk_i) begin
    if ((state_q == mc_bus_pkg::BUS_IDLE) && mem_start_i) begin
      req_q <= '{req: 1'b0, we: mem_we_i, addr: mem_addr_i, wdata: mem_wdata_i};
    end
    if (rsp_seen) begin
      rdata_q <= data_rsp_i.rdata;
      err_q   <= data_rsp_i.err;
    end
  end

  always_comb begin
    data_req_o     = req_q;
    data_req_o.req = (state_q == mc_bus_pkg::BUS_REQ);
  end

  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;
  assign mem_err_o   = err_q;

endmodule

`default_nettype wire

//--- sim.f
mc_core_pkg.sv
mc_bus_pkg.sv
mc_fetch.sv
mc_lsu.sv
mc_controller.sv
mc_core_top.sv
mc_core_props.sv
tb_bus_responder.sv
tb_mc_checker.sv
tb_mc_top.sv

//--- tb_bus_responder.sv
// ####################
// Word memory answering one request/grant/rvalid bus
// Random grant and response delays, optional error region
// ####################

`timescale 1ns/1ns
`default_nettype none

module tb_bus_responder (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [31:0]          seed_i,
  input  logic                 err_enable_i,
  input  mc_bus_pkg::bus_req_t req_i,
  output mc_bus_pkg::bus_rsp_t rsp_o
);

  logic [15:0] mem [0:4095];
  logic [31:0] rnd_q;
  logic [1:0]  wait_q;
  logic [1:0]  cnt_q;
  logic        pend_q;
  logic [15:0] rdata_q;
  logic        err_q;
  logic        accept;
  logic        addr_err;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Top four address bits all ones
  assign addr_err = err_enable_i && (req_i.addr[11:8] == 4'hf);
  assign accept   = req_i.req && !pend_q && (wait_q >= rnd_q[31:30]);

  always_comb begin
    rsp_o        = '0;
    rsp_o.gnt    = accept;
    rsp_o.rvalid = pend_q && (cnt_q == 2'd0);
    rsp_o.rdata  = rdata_q;
    rsp_o.err    = err_q;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rnd_q   <= seed_i;
      wait_q  <= 2'd0;
      cnt_q   <= 2'd0;
      pend_q  <= 1'b0;
      rdata_q <= 16'h0;
      err_q   <= 1'b0;
    end else if (accept) begin
      wait_q  <= 2'd0;
      pend_q  <= 1'b1;
      cnt_q   <= 2'(rnd_q[29:28] % 3);
      rnd_q   <= lcg_step(rnd_q);
      err_q   <= addr_err;
      rdata_q <= addr_err ? 16'h0 : mem[req_i.addr];
      // Errored stores leave memory alone
      if (req_i.we && !addr_err) begin
        mem[req_i.addr] = req_i.wdata;
      end
    end else begin
      if (req_i.req) begin
        wait_q <= wait_q + 2'd1;
      end
      if (pend_q && (cnt_q == 2'd0)) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_mc_checker.sv
// ####################
// Instruction-level model of the mc core
// Checks retirements, stop status and final data memory per test
// ####################

`timescale 1ns/1ns
`default_nettype none

module tb_mc_checker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 fetch_enable_i,
  input  logic                 instr_req_i,
  input  logic                 data_req_i,
  input  logic                 retire_valid_i,
  input  mc_core_pkg::retire_t retire_i,
  input  logic                 core_sleep_i,
  input  logic                 alert_bus_i,
  input  logic                 alert_illegal_i
);

  logic [15:0] imem_model [0:4095];
  logic [15:0] dmem_model [0:4095];
  logic [11:0] pc_m;
  logic [15:0] acc_m;
  logic        halted_m;
  logic        stopped_q;
  int          errs;
  int          retired;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  function automatic logic is_mem_op(input logic [3:0] op);
    return (op == mc_core_pkg::OP_LD) || (op == mc_core_pkg::OP_ST) ||
           (op == mc_core_pkg::OP_ADD);
  endfunction

  task automatic compare_hex(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act) begin
      $display("Fail %s at pc %h: expected %h, got %h", name, pc_m, exp, act);
      errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error at pc %h: %s", pc_m, msg);
    errs++;
  endtask

  task automatic start_test();
    pc_m     = '0;
    acc_m    = '0;
    halted_m = 1'b0;
    errs     = 0;
    retired  = 0;
  endtask

  // One instruction of the model against one retirement
  task automatic step_model();
    logic [15:0] ins;
    logic [11:0] opd;
    logic [11:0] pc_n;
    logic [15:0] acc_n;
    ins   = imem_model[pc_m];
    opd   = ins[11:0];
    pc_n  = pc_m + 12'd1;
    acc_n = acc_m;
    case (ins[15:12])
      mc_core_pkg::OP_LDI:  acc_n = {4'h0, opd};
      mc_core_pkg::OP_LD:   acc_n = dmem_model[opd];
      mc_core_pkg::OP_ST:   dmem_model[opd] = acc_m;
      mc_core_pkg::OP_ADD:  acc_n = acc_m + dmem_model[opd];
      mc_core_pkg::OP_XORI: acc_n = acc_m ^ {4'h0, opd};
      mc_core_pkg::OP_BEQZ: pc_n = (acc_m == 16'h0) ? opd : pc_n;
      mc_core_pkg::OP_JMP:  pc_n = opd;
      mc_core_pkg::OP_HALT: halted_m = 1'b1;
      default:              report_error("illegal opcode retired");
    endcase
    if (is_mem_op(ins[15:12]) && (opd[11:8] == 4'hf)) begin
      report_error("data access to an error address retired");
    end
    compare_hex("retire_o.pc", {4'h0, pc_m}, {4'h0, retire_i.pc});
    compare_hex("retire_o.instr", ins, retire_i.instr);
    compare_hex("retire_o.acc", acc_n, retire_i.acc);
    pc_m  = pc_n;
    acc_m = acc_n;
    retired++;
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      stopped_q <= 1'b0;
    end else begin
      if (stopped_q && retire_valid_i) begin
        report_error("retirement after the core stopped");
      end
      if (stopped_q && (instr_req_i || data_req_i)) begin
        report_error("bus request after the core stopped");
      end
      if (!fetch_enable_i && instr_req_i) begin
        report_error("instruction request while fetch enable is low");
      end
      if (retire_valid_i && !stopped_q) begin
        step_model();
      end
      stopped_q <= core_sleep_i || alert_bus_i || alert_illegal_i;
    end
  end

  task automatic finish_test(input int test_no, input string name);
    int          a;
    int          mism;
    logic [15:0] ins;
    logic        exp_ill;
    logic        exp_bus;
    mism = 0;
    for (a = 0; a < 4096; a++) begin
      if (dmem_model[a] !== tb_mc_top.u_dmem.mem[a]) begin
        if (mism == 0) begin
          $display("Fail u_dmem.mem[%h]: expected %h, got %h", a[11:0], dmem_model[a],
                   tb_mc_top.u_dmem.mem[a]);
        end
        mism++;
      end
    end
    errs += mism;
    // Expected stop cause from the instruction at the model's pc
    ins     = imem_model[pc_m];
    exp_ill = !halted_m && ins[15];
    exp_bus = !halted_m && !ins[15] && is_mem_op(ins[15:12]) && (ins[11:8] == 4'hf);
    if (!halted_m && !exp_ill && !exp_bus) begin
      report_error("core stopped where the model has no cause to stop");
    end
    compare_hex("core_sleep_o", {15'h0, halted_m}, {15'h0, core_sleep_i});
    compare_hex("alert_illegal_o", {15'h0, exp_ill}, {15'h0, alert_illegal_i});
    compare_hex("alert_major_bus_o", {15'h0, exp_bus}, {15'h0, alert_bus_i});
    $display("Test %0d (%s): %s, %0d retired, %0d errors", test_no, name,
             (errs == 0) ? "pass" : "fail", retired, errs);
    if (errs == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
  endtask

endmodule

`default_nettype wire

//--- tb_mc_top.sv
// ####################
// Testbench top for the mc core with random programs and bus delays
// Each test resets the core, loads memories, runs until sleep or alert
// ####################

`timescale 1ns/1ns
`default_nettype none

module tb_mc_top;

  localparam int NUM_TESTS     = 14;
  localparam int MAX_INSTR     = 64;
  localparam int RESET_CYCLES  = 10;
  localparam int GATE_CYCLES   = 20;
  localparam int SETTLE_CYCLES = 8;
  // Two transactions of 7 cycles per instruction, plus per-test overhead
  localparam int CYCLE_LIMIT   =
    NUM_TESTS * (MAX_INSTR * 2 * 7 + RESET_CYCLES + GATE_CYCLES + SETTLE_CYCLES);

  logic                 clk;
  logic                 arst_n;
  logic                 fetch_enable;
  mc_bus_pkg::bus_req_t instr_req;
  mc_bus_pkg::bus_rsp_t instr_rsp;
  mc_bus_pkg::bus_req_t data_req;
  mc_bus_pkg::bus_rsp_t data_rsp;
  logic                 retire_valid;
  mc_core_pkg::retire_t retire;
  logic                 core_sleep;
  logic                 alert_bus;
  logic                 alert_illegal;
  logic [31:0]          rng;
  logic [31:0]          imem_seed;
  logic [31:0]          dmem_seed;
  int                   cycles = 0;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      0:       return "arithmetic";
      1:       return "load/store";
      2:       return "control flow";
      3:       return "back-pressure";
      4:       return "illegal opcode";
      5:       return "data bus error";
      default: return "start gating";
    endcase
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  mc_core_top uut (
    .clk_i             (clk          ),
    .arst_n_i          (arst_n       ),
    .fetch_enable_i    (fetch_enable ),
    .instr_req_o       (instr_req    ),
    .instr_rsp_i       (instr_rsp    ),
    .data_req_o        (data_req     ),
    .data_rsp_i        (data_rsp     ),
    .retire_valid_o    (retire_valid ),
    .retire_o          (retire       ),
    .core_sleep_o      (core_sleep   ),
    .alert_major_bus_o (alert_bus    ),
    .alert_illegal_o   (alert_illegal)
  );

  tb_bus_responder u_imem (
    .clk_i        (clk      ),
    .arst_n_i     (arst_n   ),
    .seed_i       (imem_seed),
    .err_enable_i (1'b0     ),
    .req_i        (instr_req),
    .rsp_o        (instr_rsp)
  );

  tb_bus_responder u_dmem (
    .clk_i        (clk      ),
    .arst_n_i     (arst_n   ),
    .seed_i       (dmem_seed),
    .err_enable_i (1'b1     ),
    .req_i        (data_req ),
    .rsp_o        (data_rsp )
  );

  tb_mc_checker u_chk (
    .clk_i           (clk          ),
    .arst_n_i        (arst_n       ),
    .fetch_enable_i  (fetch_enable ),
    .instr_req_i     (instr_req.req),
    .data_req_i      (data_req.req ),
    .retire_valid_i  (retire_valid ),
    .retire_i        (retire       ),
    .core_sleep_i    (core_sleep   ),
    .alert_bus_i     (alert_bus    ),
    .alert_illegal_i (alert_illegal)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles without the core stopping", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Forward-only branches, HALT at the end
  task automatic build_program(input int kind);
    int          a;
    int          len;
    int          bad_at;
    int          tgt;
    logic [3:0]  op;
    logic [11:0] opd;
    rng    = lcg_step(rng);
    len    = 8 + (rng[31:24] % (MAX_INSTR - 7));
    bad_at = rng[15:8] % (len - 1);
    for (a = 0; a < 4096; a++) begin
      rng                 = lcg_step(rng);
      u_dmem.mem[a]       = rng[31:16];
      u_chk.dmem_model[a] = rng[31:16];
      u_imem.mem[a]       = {mc_core_pkg::OP_HALT, a[11:0]};
      u_chk.imem_model[a] = {mc_core_pkg::OP_HALT, a[11:0]};
    end
    for (a = 0; a < len - 1; a++) begin
      rng = lcg_step(rng);
      opd = rng[11:0];
      case (kind)
        0: op = (rng[17:16] == 2'd0) ? mc_core_pkg::OP_LDI :
                (rng[17:16] == 2'd1) ? mc_core_pkg::OP_XORI : mc_core_pkg::OP_ADD;
        1:       op = {2'b00, rng[17:16]};
        4, 5:    op = 4'(rng[18:16] % 5);
        default: op = 4'(rng[18:16] % 7);
      endcase
      if ((op == mc_core_pkg::OP_LD) || (op == mc_core_pkg::OP_ST) ||
          (op == mc_core_pkg::OP_ADD)) begin
        // Small range on load/store tests so addresses collide
        opd = (kind == 1) ? {6'h0, rng[5:0]} : {1'b0, rng[10:0]};
      end
      if ((op == mc_core_pkg::OP_LDI) && rng[20]) begin
        opd = 12'h0;
      end
      if ((op == mc_core_pkg::OP_BEQZ) || (op == mc_core_pkg::OP_JMP)) begin
        tgt = a + 1 + rng[2:0];
        if (tgt > len - 1) begin
          tgt = len - 1;
        end
        opd = 12'(tgt);
      end
      if ((kind == 4) && (a == bad_at)) begin
        op = {1'b1, rng[23:21]};
      end
      if ((kind == 5) && (a == bad_at)) begin
        op  = mc_core_pkg::OP_LD;
        opd = {4'hf, rng[7:0]};
      end
      u_imem.mem[a]       = {op, opd};
      u_chk.imem_model[a] = {op, opd};
    end
    u_imem.mem[len-1]       = {mc_core_pkg::OP_HALT, 12'h0};
    u_chk.imem_model[len-1] = {mc_core_pkg::OP_HALT, 12'h0};
  endtask

  initial begin
    int t;
    int kind;
    arst_n       = 1'b0;
    fetch_enable = 1'b0;
    rng          = 32'hfa31_d0be;
    imem_seed    = 32'h0;
    dmem_seed    = 32'h0;
    for (t = 0; t < NUM_TESTS; t++) begin
      kind = t % 7;
      @(negedge clk);
      arst_n       = 1'b0;
      fetch_enable = 1'b0;
      build_program(kind);
      rng       = lcg_step(rng);
      imem_seed = rng ^ 32'h0000_5a5a;
      dmem_seed = rng ^ 32'ha5a5_0000;
      u_chk.start_test();
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      // Enable held low longer on the gating test
      if (kind == 6) begin
        repeat (GATE_CYCLES) @(negedge clk);
      end else begin
        repeat (1 + rng[1:0]) @(negedge clk);
      end
      fetch_enable = 1'b1;
      while (!(core_sleep || alert_bus || alert_illegal)) begin
        @(negedge clk);
      end
      repeat (SETTLE_CYCLES) @(negedge clk);
      u_chk.finish_test(t, kind_name(kind));
    end
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d", NUM_TESTS,
             u_chk.pass_cnt, u_chk.fail_cnt, uut.u_props.violations);
    if ((u_chk.fail_cnt == 0) && (uut.u_props.violations == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
